//--- accelTile_macros.svh
`ifndef ACCELTILE_MACROS_SVH
`define ACCELTILE_MACROS_SVH

// ==================================================
// tile sizes
// ==================================================
`define DATA_W       32           // core and fabric data word
`define IMEM_DEPTH   256          // instruction words
`define DMEM_DEPTH   256          // data words
`define TILE_ID_W    4            // fabric tile id

// ==================================================
// accelerator window, core byte addresses
// ==================================================
`define ACC_XOR_IN   32'h0000_F000 // [7:0] op1, [15:8] op2
`define ACC_XOR_OUT  32'h0000_F004 // read only
`define ACC_MUL_A    32'h0000_F008
`define ACC_MUL_B    32'h0000_F00C // write launches multiply
`define ACC_MUL_OUT  32'h0000_F010 // read stalls until result held

// fabric word address of the done flag
`define STATUS_ADDR  16'hFFFF

`endif

//--- accelTile_pkg.sv
`default_nettype none

`include "accelTile_macros.svh"

package accelTile_pkg;

   typedef logic [`TILE_ID_W-1:0] tTileId;

   typedef enum logic [2:0] {
      WRITE_I  = 3'd0,   // load program word
      WRITE_D  = 3'd1,   // store data word
      READ_D   = 3'd2,   // read data or status word
      START    = 3'd3,   // run core from pc 0
      READ_RSP = 3'd4    // response to READ_D
   } tFabOp;

   typedef struct packed {
      tFabOp               opcode;
      tTileId              srcTile;
      tTileId              dstTile;
      logic [15:0]         addr;     // word address
      logic [`DATA_W-1:0]  data;
   } tTileTrans;

   typedef struct packed {
      logic wrRspReady;              // no write responses in this tile
      logic rdRspReady;
   } tFabReady;

   typedef struct packed {
      logic [31:0]        address;   // byte address
      logic [`DATA_W-1:0] wrData;
      logic               wrEn;
      logic               rdEn;
   } tCore2MemReq;

   typedef struct packed {
      logic [15:0] mulA;
      logic [15:0] mulB;
      logic        mulStart;         // single cycle pulse
   } tAccelInputs;

   typedef struct packed {
      logic [31:0] mulResult;
      logic        mulValid;
   } tAccelOutputs;

   // i-type fields
   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } tIView;

   // s/b-type fields, immediate split around rs1/rs2
   typedef struct packed {
      logic [6:0]  immHi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  immLo;
      logic [6:0]  opcode;
   } tSView;

   typedef union packed {
      tIView iView;
      tSView sView;
   } tInstr;

endpackage

`default_nettype wire

//--- accelCoreFarm.sv
`timescale 1ns/1ns
`default_nettype none

module accelCoreFarm (
   input  logic                         Clk,
   input  logic                         rstN,
   input  logic [7:0]                   xorInp1,
   input  logic [7:0]                   xorInp2,
   output logic [7:0]                   xorResult,
   input  var accelTile_pkg::tAccelInputs mulInputs,
   output accelTile_pkg::tAccelOutputs  mulOutputs
);

   logic [31:0] prodQ;        // stage 1 product
   logic [31:0] resQ;         // stage 2 output reg
   logic [1:0]  validPipeQ;

   assign xorResult = xorInp1 ^ xorInp2;   // combinational path

   always_ff @(posedge Clk) begin
      prodQ <= mulInputs.mulA * mulInputs.mulB;
      resQ  <= prodQ;
   end

   // valid follows data, two deep
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         validPipeQ <= 2'b00;
      end else begin
         validPipeQ <= {validPipeQ[0], mulInputs.mulStart};
      end
   end

   assign mulOutputs.mulResult = resQ;
   assign mulOutputs.mulValid  = validPipeQ[1];

endmodule

`default_nettype wire

//--- miniCore.sv
`timescale 1ns/1ns
`default_nettype none

`include "accelTile_macros.svh"

module miniCore #(
   parameter int RF_NUM_MSB = 15                  // 15 for rv32e, 31 for full rf
) (
   input  logic                       Clock,
   input  logic                       rstN,
   input  logic                       coreRun,
   output logic                       halted,
   output logic                       ReadyQ101H,
   output logic [31:0]                PcQ100H,
   input  logic [31:0]                PreInstructionQ101H,
   input  logic                       DMemReady,
   output accelTile_pkg::tCore2MemReq Core2DmemReqQ103H,
   input  logic [31:0]                DMemRdRspQ104H
);

   localparam logic [6:0] OpLui    = 7'b0110111;
   localparam logic [6:0] OpImm    = 7'b0010011;
   localparam logic [6:0] OpReg    = 7'b0110011;
   localparam logic [6:0] OpLoad   = 7'b0000011;
   localparam logic [6:0] OpStore  = 7'b0100011;
   localparam logic [6:0] OpBranch = 7'b1100011;
   localparam logic [6:0] OpSystem = 7'b1110011;

   typedef enum logic [2:0] {
      S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB
   } tState;

   tState                stateQ;
   logic [31:0]          pcQ;
   accelTile_pkg::tInstr instrQ;
   accelTile_pkg::tInstr fetched;
   logic [`DATA_W-1:0]   rf [1:RF_NUM_MSB];     // x0 not stored
   logic [`DATA_W-1:0]   rs1Val;
   logic [`DATA_W-1:0]   rs2Val;
   logic [31:0]          immI;
   logic [31:0]          immS;
   logic [31:0]          immB;
   logic [`DATA_W-1:0]   aluOut;
   logic [6:0]           opcode;
   logic                 isLoad;
   logic                 brTaken;
   logic                 wbEn;
   logic [`DATA_W-1:0]   wbData;

   function automatic logic [`DATA_W-1:0] rdReg(input logic [4:0] idx);
      if (idx == 5'd0 || idx > RF_NUM_MSB) begin  // x0 and absent regs read 0
         return '0;
      end
      return rf[idx];
   endfunction

   // ==================================================
   // decode
   // ==================================================
   assign fetched = PreInstructionQ101H;
   assign opcode  = instrQ.iView.opcode;
   assign isLoad  = (opcode == OpLoad);
   assign rs1Val  = rdReg(instrQ.iView.rs1);
   assign rs2Val  = rdReg(instrQ.sView.rs2);        // rs2 only lives in the s view
   assign immI    = {{20{instrQ.iView.imm[11]}}, instrQ.iView.imm};
   assign immS    = {{20{instrQ.sView.immHi[6]}}, instrQ.sView.immHi, instrQ.sView.immLo};
   assign immB    = {{20{instrQ.sView.immHi[6]}}, instrQ.sView.immLo[0],
                     instrQ.sView.immHi[5:0], instrQ.sView.immLo[4:1], 1'b0};
   assign brTaken = (opcode == OpBranch) && (instrQ.sView.funct3 == 3'b001)
                    && (rs1Val != rs2Val);             // bne only

   always_comb begin
      case (opcode)
         OpLui:   aluOut = {instrQ[31:12], 12'h000};
         OpImm:   aluOut = rs1Val + immI;              // addi
         OpReg:   aluOut = rs1Val + rs2Val;            // add
         default: aluOut = '0;
      endcase
   end

   // ==================================================
   // memory side
   // ==================================================
   assign ReadyQ101H = (stateQ == S_FETCH);
   assign PcQ100H    = pcQ;
   assign halted     = (stateQ == S_EXEC) && (opcode == OpSystem); // ecall

   assign Core2DmemReqQ103H.address = rs1Val + (isLoad ? immI : immS);
   assign Core2DmemReqQ103H.wrData  = rs2Val;
   assign Core2DmemReqQ103H.wrEn    = (stateQ == S_MEM) && !isLoad;
   assign Core2DmemReqQ103H.rdEn    = (stateQ == S_MEM) && isLoad;

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         stateQ <= S_IDLE;
         pcQ    <= '0;
      end else begin
         case (stateQ)
            S_IDLE: begin
               if (coreRun) begin
                  pcQ    <= '0;
                  stateQ <= S_FETCH;
               end
            end
            S_FETCH:  stateQ <= S_DECODE;             // imem read in flight
            S_DECODE: begin
               if (fetched.iView.opcode == OpLoad || fetched.iView.opcode == OpStore) begin
                  stateQ <= S_MEM;
               end else begin
                  stateQ <= S_EXEC;
               end
            end
            S_EXEC: begin
               if (halted) begin
                  stateQ <= S_IDLE;
               end else begin
                  pcQ    <= brTaken ? pcQ + immB : pcQ + 32'd4;
                  stateQ <= S_FETCH;
               end
            end
            S_MEM: begin
               if (DMemReady) begin
                  stateQ <= S_WB;                     // else hold request
               end
            end
            default: begin                            // S_WB
               pcQ    <= pcQ + 32'd4;
               stateQ <= S_FETCH;
            end
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (stateQ == S_DECODE) begin
         instrQ <= fetched;
      end
   end

   // ==================================================
   // register file writeback
   // ==================================================
   assign wbEn   = ((stateQ == S_EXEC) && (opcode == OpLui || opcode == OpImm || opcode == OpReg))
                   || ((stateQ == S_WB) && isLoad);
   assign wbData = (stateQ == S_WB) ? DMemRdRspQ104H : aluOut;

   always_ff @(posedge Clock) begin
      if (wbEn && instrQ.iView.rd != 5'd0 && instrQ.iView.rd <= RF_NUM_MSB) begin
         rf[instrQ.iView.rd] <= wbData;
      end
   end

endmodule

`default_nettype wire

//--- accelCoreMemWrap.sv
`timescale 1ns/1ns
`default_nettype none

`include "accelTile_macros.svh"

module accelCoreMemWrap (
   input  logic                        Clock,
   input  logic                        rstN,
   input  accelTile_pkg::tTileId       localTileId,
   // core instruction side
   input  logic                        ReadyQ101H,
   input  logic [31:0]                 PcQ100H,
   output logic [31:0]                 PreInstructionQ101H,
   // core data side
   input  logic [`DATA_W-1:0]          DMemWrDataQ103H,
   input  logic [31:0]                 DMemAddressQ103H,
   input  logic [`DATA_W/8-1:0]        DMemByteEnQ103H,
   input  logic                        DMemWrEnQ103H,
   input  logic                        DMemRdEnQ103H,
   output logic [`DATA_W-1:0]          DMemRdRspQ104H,
   output logic                        DMemReady,
   output logic                        coreRun,
   input  logic                        halted,
   // fabric
   input  logic                        InFabricValidQ503H,
   input  var accelTile_pkg::tTileTrans InFabricQ503H,
   output logic                        miniCoreReady,
   output logic                        OutFabricValidQ505H,
   output accelTile_pkg::tTileTrans    OutFabricQ505H,
   input  var accelTile_pkg::tFabReady fabReady,
   // accel farm
   output logic [7:0]                  xorInp1,
   output logic [7:0]                  xorInp2,
   input  logic [7:0]                  xorResult,
   output accelTile_pkg::tAccelInputs  mulInputs,
   input  var accelTile_pkg::tAccelOutputs mulOutputs
);

   localparam int ImemAw = $clog2(`IMEM_DEPTH);
   localparam int DmemAw = $clog2(`DMEM_DEPTH);
   localparam logic [31:0] AccXorIn  = `ACC_XOR_IN;
   localparam logic [31:0] AccXorOut = `ACC_XOR_OUT;
   localparam logic [31:0] AccMulA   = `ACC_MUL_A;
   localparam logic [31:0] AccMulB   = `ACC_MUL_B;
   localparam logic [31:0] AccMulOut = `ACC_MUL_OUT;

   logic [31:0]              imem [`IMEM_DEPTH];
   logic [`DATA_W-1:0]       dmem [`DMEM_DEPTH];
   logic                     fabAcc;
   logic                     rsp504ValidQ;
   accelTile_pkg::tTileTrans rsp504Q;
   logic                     doneQ;
   logic                     accelHit;
   logic [`DATA_W-1:0]       accelRdData;
   logic                     dmemWe;
   logic [DmemAw-1:0]        dmemWIdx;
   logic [`DATA_W-1:0]       dmemWData;
   logic [`DATA_W/8-1:0]     dmemBe;
   logic [15:0]              xorRegQ;
   logic [15:0]              mulAQ;
   logic [15:0]              mulBQ;
   logic                     mulStartQ;
   logic [31:0]              mulResQ;
   logic                     mulHeldQ;
   logic                     mulRdMiss;

   // ==================================================
   // fabric request side
   // ==================================================
   assign miniCoreReady = !coreRun && !rsp504ValidQ && !OutFabricValidQ505H; // one in flight
   assign fabAcc        = InFabricValidQ503H && miniCoreReady;

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         coreRun <= 1'b0;
         doneQ   <= 1'b0;
      end else if (fabAcc && InFabricQ503H.opcode == accelTile_pkg::START) begin
         coreRun <= 1'b1;
         doneQ   <= 1'b0;
      end else if (halted) begin
         coreRun <= 1'b0;
         doneQ   <= 1'b1;
      end
   end

   always_ff @(posedge Clock) begin
      if (fabAcc && InFabricQ503H.opcode == accelTile_pkg::WRITE_I) begin
         imem[InFabricQ503H.addr[ImemAw-1:0]] <= InFabricQ503H.data;
      end
      if (ReadyQ101H) begin
         PreInstructionQ101H <= imem[PcQ100H[ImemAw+1:2]]; // byte pc to word
      end
   end

   // ==================================================
   // response pipe, q504 then q505
   // ==================================================
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         rsp504ValidQ        <= 1'b0;
         OutFabricValidQ505H <= 1'b0;
      end else begin
         rsp504ValidQ <= fabAcc && (InFabricQ503H.opcode == accelTile_pkg::READ_D);
         if (!OutFabricValidQ505H || fabReady.rdRspReady) begin
            OutFabricValidQ505H <= rsp504ValidQ;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (fabAcc) begin
         rsp504Q.opcode  <= accelTile_pkg::READ_RSP;
         rsp504Q.srcTile <= localTileId;
         rsp504Q.dstTile <= InFabricQ503H.srcTile;   // reply to requester
         rsp504Q.addr    <= InFabricQ503H.addr;
         rsp504Q.data    <= (InFabricQ503H.addr == `STATUS_ADDR) ?
                            {{(`DATA_W-1){1'b0}}, doneQ} : dmem[InFabricQ503H.addr[DmemAw-1:0]];
      end
      if (!OutFabricValidQ505H || fabReady.rdRspReady) begin
         OutFabricQ505H <= rsp504Q;                  // held under back-pressure
      end
   end

   // ==================================================
   // data memory, shared write port
   // ==================================================
   assign accelHit  = (DMemAddressQ103H[31:12] == AccXorIn[31:12]);
   assign dmemWe    = (fabAcc && InFabricQ503H.opcode == accelTile_pkg::WRITE_D)
                      || (DMemWrEnQ103H && !accelHit);
   assign dmemWIdx  = coreRun ? DMemAddressQ103H[DmemAw+1:2] : InFabricQ503H.addr[DmemAw-1:0];
   assign dmemWData = coreRun ? DMemWrDataQ103H : InFabricQ503H.data;
   assign dmemBe    = coreRun ? DMemByteEnQ103H : '1;

   always_ff @(posedge Clock) begin
      if (dmemWe) begin
         for (int b = 0; b < `DATA_W/8; b++) begin
            if (dmemBe[b]) begin
               dmem[dmemWIdx][8*b +: 8] <= dmemWData[8*b +: 8];
            end
         end
      end
      if (DMemRdEnQ103H && DMemReady) begin
         DMemRdRspQ104H <= accelHit ? accelRdData : dmem[DMemAddressQ103H[DmemAw+1:2]];
      end
   end

   // ==================================================
   // accelerator registers
   // ==================================================
   always_comb begin
      case (DMemAddressQ103H)
         AccXorIn:  accelRdData = {{(`DATA_W-16){1'b0}}, xorRegQ};
         AccXorOut: accelRdData = {{(`DATA_W-8){1'b0}}, xorResult};
         AccMulOut: accelRdData = mulResQ;
         default:   accelRdData = '0;
      endcase
   end

   assign mulRdMiss = DMemRdEnQ103H && (DMemAddressQ103H == AccMulOut) && !mulHeldQ;
   assign DMemReady = !mulRdMiss;                    // stall load until product held
   assign xorInp1   = xorRegQ[7:0];
   assign xorInp2   = xorRegQ[15:8];
   assign mulInputs = '{mulA: mulAQ, mulB: mulBQ, mulStart: mulStartQ};

   always_ff @(posedge Clock) begin
      if (DMemWrEnQ103H && DMemAddressQ103H == AccXorIn) xorRegQ <= DMemWrDataQ103H[15:0];
      if (DMemWrEnQ103H && DMemAddressQ103H == AccMulA)  mulAQ   <= DMemWrDataQ103H[15:0];
      if (DMemWrEnQ103H && DMemAddressQ103H == AccMulB)  mulBQ   <= DMemWrDataQ103H[15:0];
      if (mulOutputs.mulValid) mulResQ <= mulOutputs.mulResult;
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         mulStartQ <= 1'b0;
         mulHeldQ  <= 1'b0;
      end else begin
         mulStartQ <= DMemWrEnQ103H && (DMemAddressQ103H == AccMulB); // launch pulse
         if (mulOutputs.mulValid) begin
            mulHeldQ <= 1'b1;
         end else if (DMemRdEnQ103H && DMemAddressQ103H == AccMulOut) begin
            mulHeldQ <= 1'b0;                        // taken by the load
         end
      end
   end

endmodule

`default_nettype wire

//--- accelCoreTop.sv
`timescale 1ns/1ns
`default_nettype none

`include "accelTile_macros.svh"

module accelCoreTop #(
   parameter int RF_NUM_MSB = 15                 // rv32e register count
) (
   input  logic                         Clock,
   input  logic                         rstN,
   input  accelTile_pkg::tTileId        localTileId,
   // ==================================================
   // fabric
   // ==================================================
   input  logic                         InFabricValidQ503H,
   input  var accelTile_pkg::tTileTrans InFabricQ503H,
   output logic                         miniCoreReady,
   output logic                         OutFabricValidQ505H,
   output accelTile_pkg::tTileTrans     OutFabricQ505H,
   input  var accelTile_pkg::tFabReady  fabReady
);

   logic [31:0]                PcQ100H;
   logic [31:0]                PreInstructionQ101H;
   logic                       ReadyQ101H;
   logic [`DATA_W-1:0]         DMemRdRspQ104H;
   logic                       DMemReady;
   logic [`DATA_W/8-1:0]       DMemByteEnQ103H;
   accelTile_pkg::tCore2MemReq Core2DmemReqQ103H;
   logic                       coreRun;
   logic                       halted;
   logic [7:0]                 xorInp1;
   logic [7:0]                 xorInp2;
   logic [7:0]                 xorResult;
   accelTile_pkg::tAccelInputs  mulInputs;
   accelTile_pkg::tAccelOutputs mulOutputs;

   assign DMemByteEnQ103H = '1;                 // word access only

   miniCore #(.RF_NUM_MSB(RF_NUM_MSB)) u_miniCore (
      .Clock               (Clock),
      .rstN                (rstN),
      .coreRun             (coreRun),
      .halted              (halted),
      .ReadyQ101H          (ReadyQ101H),
      .PcQ100H             (PcQ100H),
      .PreInstructionQ101H (PreInstructionQ101H),
      .DMemReady           (DMemReady),
      .Core2DmemReqQ103H   (Core2DmemReqQ103H),
      .DMemRdRspQ104H      (DMemRdRspQ104H)
   );

   accelCoreMemWrap u_accelCoreMemWrap (
      .Clock               (Clock),
      .rstN                (rstN),
      .localTileId         (localTileId),
      .ReadyQ101H          (ReadyQ101H),
      .PcQ100H             (PcQ100H),
      .PreInstructionQ101H (PreInstructionQ101H),
      .DMemWrDataQ103H     (Core2DmemReqQ103H.wrData),   // request split per field
      .DMemAddressQ103H    (Core2DmemReqQ103H.address),
      .DMemByteEnQ103H     (DMemByteEnQ103H),
      .DMemWrEnQ103H       (Core2DmemReqQ103H.wrEn),
      .DMemRdEnQ103H       (Core2DmemReqQ103H.rdEn),
      .DMemRdRspQ104H      (DMemRdRspQ104H),
      .DMemReady           (DMemReady),
      .coreRun             (coreRun),
      .halted              (halted),
      .InFabricValidQ503H  (InFabricValidQ503H),
      .InFabricQ503H       (InFabricQ503H),
      .miniCoreReady       (miniCoreReady),
      .OutFabricValidQ505H (OutFabricValidQ505H),
      .OutFabricQ505H      (OutFabricQ505H),
      .fabReady            (fabReady),
      .xorInp1             (xorInp1),
      .xorInp2             (xorInp2),
      .xorResult           (xorResult),
      .mulInputs           (mulInputs),
      .mulOutputs          (mulOutputs)
   );

   accelCoreFarm u_accelCoreFarm (
      .Clk        (Clock),
      .rstN       (rstN),
      .xorInp1    (xorInp1),
      .xorInp2    (xorInp2),
      .xorResult  (xorResult),
      .mulInputs  (mulInputs),
      .mulOutputs (mulOutputs)
   );

endmodule

`default_nettype wire

//--- tbClockGen.sv
`timescale 1ns/1ns
`default_nettype none

module tbClockGen #(
   parameter int ResetCycles = 16             // cycles with rstN low
) (
   output logic Clock,
   output logic rstN
);

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;              // 4 ns period
   end

   initial begin
      rstN = 1'b0;
      repeat (ResetCycles) @(posedge Clock);
      @(negedge Clock);                       // release away from the active edge
      rstN = 1'b1;
   end

endmodule

`default_nettype wire

//--- accelTile_assert.sv
`timescale 1ns/1ns
`default_nettype none

module accelTile_assert (
   input  logic                         Clock,
   input  logic                         rstN,
   input  logic                         miniCoreReady,
   input  logic                         OutFabricValidQ505H,
   input  var accelTile_pkg::tTileTrans OutFabricQ505H,
   input  var accelTile_pkg::tFabReady  fabReady
);

   int failCount = 0;                         // read by the testbench at the end

   // held response must not move
   rspStableChk: assert property (@(posedge Clock) disable iff (!rstN)
      OutFabricValidQ505H && !fabReady.rdRspReady
      |=> OutFabricValidQ505H && $stable(OutFabricQ505H))
   else begin
      failCount++;
      $error("fabric response changed while fabReady was low");
   end

   // back-pressured response keeps the tile closed to new requests
   readyLowChk: assert property (@(posedge Clock) disable iff (!rstN)
      OutFabricValidQ505H && !fabReady.rdRspReady |=> !miniCoreReady)
   else begin
      failCount++;
      $error("miniCoreReady high while a response is held");
   end

   resetValidChk: assert property (@(posedge Clock)
      !rstN |=> !OutFabricValidQ505H)
   else begin
      failCount++;
      $error("fabric valid not low after reset");
   end

endmodule

`default_nettype wire

//--- accelTile_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "accelTile_macros.svh"

module accelTile_tb;

   localparam int         NumRand  = 16;       // random write/read pairs
   localparam int         VecWords = 64;
   localparam logic [3:0] TileId   = 4'h3;     // this tile
   localparam logic [3:0] HostId   = 4'h9;     // requester on the fabric

   logic                     Clock;
   logic                     rstN;
   logic                     InFabricValidQ503H;
   accelTile_pkg::tTileTrans InFabricQ503H;
   logic                     miniCoreReady;
   logic                     OutFabricValidQ505H;
   accelTile_pkg::tTileTrans OutFabricQ505H;
   accelTile_pkg::tFabReady  fabReady;
   logic [31:0]              vecMem [VecWords];
   int                       valueErrs;
   int                       otherErrs;
   int                       limitCycles = 0;

   tbClockGen u_tbClockGen (.Clock(Clock), .rstN(rstN));

   accelCoreTop u_accelCoreTop (
      .Clock               (Clock),
      .rstN                (rstN),
      .localTileId         (TileId),
      .InFabricValidQ503H  (InFabricValidQ503H),
      .InFabricQ503H       (InFabricQ503H),
      .miniCoreReady       (miniCoreReady),
      .OutFabricValidQ505H (OutFabricValidQ505H),
      .OutFabricQ505H      (OutFabricQ505H),
      .fabReady            (fabReady)
   );

   bind accelCoreMemWrap accelTile_assert u_accelTile_assert (
      .Clock               (Clock),
      .rstN                (rstN),
      .miniCoreReady       (miniCoreReady),
      .OutFabricValidQ505H (OutFabricValidQ505H),
      .OutFabricQ505H      (OutFabricQ505H),
      .fabReady            (fabReady)
   );

   // ==================================================
   // checks and fabric tasks
   // ==================================================
   task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         valueErrs++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkTrue(input logic cond, input string msg);
      assert (cond === 1'b1) else begin
         otherErrs++;
         $display("%s", msg);
      end
   endtask

   // called on a falling edge, returns one cycle after acceptance
   task automatic sendReq(input accelTile_pkg::tFabOp op, input logic [15:0] addr,
                          input logic [31:0] data);
      InFabricQ503H.opcode  = op;
      InFabricQ503H.srcTile = HostId;
      InFabricQ503H.dstTile = TileId;
      InFabricQ503H.addr    = addr;
      InFabricQ503H.data    = data;
      InFabricValidQ503H    = 1'b1;
      while (!miniCoreReady) begin
         @(negedge Clock);                    // watchdog bounds the wait
      end
      @(negedge Clock);                       // taken at the rising edge in between
      InFabricValidQ503H = 1'b0;
   endtask

   task automatic readWord(input logic [15:0] addr, input logic [31:0] expData);
      int lat;
      sendReq(accelTile_pkg::READ_D, addr, 32'h0);
      lat = 1;
      while (!OutFabricValidQ505H && lat < 8) begin
         @(negedge Clock);
         lat++;
      end
      checkTrue(OutFabricValidQ505H, "read request got no response");
      checkValue("rspLatency", 64'(lat), 64'd2);           // q503 to q505
      checkValue("OutFabricQ505H.opcode", 64'(OutFabricQ505H.opcode),
                 64'(accelTile_pkg::READ_RSP));
      checkValue("OutFabricQ505H.srcTile", 64'(OutFabricQ505H.srcTile), 64'(TileId));
      checkValue("OutFabricQ505H.dstTile", 64'(OutFabricQ505H.dstTile), 64'(HostId));
      checkValue("OutFabricQ505H.addr", 64'(OutFabricQ505H.addr), 64'(addr));
      checkValue("OutFabricQ505H.data", 64'(OutFabricQ505H.data), 64'(expData));
      @(negedge Clock);                       // consumed, fabReady high
   endtask

   task automatic heldRead(input logic [15:0] addr, input logic [31:0] expData);
      int                       hold;
      accelTile_pkg::tTileTrans snap;
      fabReady.rdRspReady = 1'b0;
      sendReq(accelTile_pkg::READ_D, addr, 32'h0);
      while (!OutFabricValidQ505H) begin
         @(negedge Clock);
      end
      snap = OutFabricQ505H;
      checkValue("OutFabricQ505H.data", 64'(snap.data), 64'(expData));
      hold = $urandom_range(8, 1);
      repeat (hold) begin
         @(negedge Clock);
         checkTrue(OutFabricValidQ505H, "response dropped while fabReady was low");
         checkValue("OutFabricQ505H", 64'(OutFabricQ505H), 64'(snap));
         checkValue("miniCoreReady", 64'(miniCoreReady), 64'd0);
      end
      fabReady.rdRspReady = 1'b1;
      @(negedge Clock);
      checkValue("OutFabricValidQ505H", 64'(OutFabricValidQ505H), 64'd0);
      checkValue("miniCoreReady", 64'(miniCoreReady), 64'd1);
   endtask

   // ==================================================
   // watchdog
   // ==================================================
   initial begin : watchdog
      wait (limitCycles > 0);
      repeat (limitCycles) @(posedge Clock);
      $display("timeout after %0d cycles, run did not finish", limitCycles);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin : mainSeq
      logic [15:0] addrs [NumRand];
      logic [31:0] datas [NumRand];
      logic [31:0] opA;
      logic [31:0] opB;
      logic [31:0] ruleXor;
      logic [31:0] ruleProd;
      logic [31:0] sum;
      int          progLen;
      int          pairCnt;
      int          assertFails;
      void'($urandom(32'hc475));
      valueErrs          = 0;
      otherErrs          = 0;
      sum                = 32'h0;
      InFabricValidQ503H = 1'b0;
      InFabricQ503H      = '0;
      fabReady           = '{wrRspReady: 1'b1, rdRspReady: 1'b1};
      $readmemh("accelTile_vectors.txt", vecMem);
      progLen     = vecMem[0];
      pairCnt     = vecMem[1];
      limitCycles = 40 * (2 * NumRand + progLen + 4 * pairCnt + 8)
                    + 16 * progLen * pairCnt;        // program run margin
      @(posedge rstN);
      @(negedge Clock);
      checkValue("OutFabricValidQ505H", 64'(OutFabricValidQ505H), 64'd0);
      checkValue("miniCoreReady", 64'(miniCoreReady), 64'd1);

      // random data words, one per 16-word block
      for (int i = 0; i < NumRand; i++) begin
         addrs[i] = 16'(i * 16 + $urandom_range(15, 0));
         datas[i] = $urandom;
         sendReq(accelTile_pkg::WRITE_D, addrs[i], datas[i]);
      end
      for (int i = 0; i < NumRand; i++) begin
         readWord(addrs[i], datas[i]);
      end
      heldRead(addrs[0], datas[0]);           // back-pressure
      readWord(`STATUS_ADDR, 32'h0);          // not done before start

      // ==================================================
      // program, operands and run
      // ==================================================
      for (int i = 0; i < progLen; i++) begin
         sendReq(accelTile_pkg::WRITE_I, 16'(i), vecMem[2 + i]);
      end
      sendReq(accelTile_pkg::WRITE_D, 16'h0000, 32'(pairCnt));
      for (int i = 0; i < pairCnt; i++) begin
         opA = vecMem[32 + 4 * i];
         opB = vecMem[33 + 4 * i];
         checkTrue(opB < 32'h100, "operand B in the vector file is wider than a byte");
         sum = sum + opA + opB;
         sendReq(accelTile_pkg::WRITE_D, 16'(16'h10 + i), opA);
         sendReq(accelTile_pkg::WRITE_D, 16'(16'h20 + i), opB);
      end
      sendReq(accelTile_pkg::START, 16'h0000, 32'h0);
      checkValue("miniCoreReady", 64'(miniCoreReady), 64'd0);
      while (!miniCoreReady) begin
         @(negedge Clock);                    // core running
      end
      readWord(`STATUS_ADDR, 32'h1);

      for (int i = 0; i < pairCnt; i++) begin
         opA      = vecMem[32 + 4 * i];
         opB      = vecMem[33 + 4 * i];
         ruleXor  = {24'h0, opA[7:0] ^ opB[7:0]};
         ruleProd = {16'h0, opA[15:0]} * {16'h0, opB[15:0]};
         checkValue("vector expXor", 64'(vecMem[34 + 4 * i]), 64'(ruleXor));
         checkValue("vector expProd", 64'(vecMem[35 + 4 * i]), 64'(ruleProd));
         readWord(16'(16'h30 + i), ruleXor);
         readWord(16'(16'h40 + i), ruleProd);
      end
      readWord(16'h0050, sum);                // running sum

      assertFails = u_accelCoreTop.u_accelCoreMemWrap.u_accelTile_assert.failCount;
      $display("errors: %0d value, %0d other, %0d assertion",
               valueErrs, otherErrs, assertFails);
      if (valueErrs + otherErrs + assertFails == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- accelTile_vectors.txt
// @00 program length, pair count; @02 program words, one per line
// @20 one pair per line, columns: opA opB expXor expProd
@00
0000001e 00000008
@02
00002083 // lw   x1, 0(x0)      pair count
04000113 // addi x2, x0, 0x40   operand pointer
0000f2b7 // lui  x5, 0xf        accel base
00000213 // addi x4, x0, 0      running sum
00000313 // addi x6, x0, 0      loop index
00012383 // lw   x7, 0(x2)      opA
04012403 // lw   x8, 0x40(x2)   opB
00720233 // add  x4, x4, x7
00820233 // add  x4, x4, x8
0072a423 // sw   x7, 8(x5)      mulA
0082a623 // sw   x8, 12(x5)     mulB, starts multiply
007384b3 // add  x9, x7, x7     shift opA left by 8
009484b3 // add  x9, x9, x9
009484b3 // add  x9, x9, x9
009484b3 // add  x9, x9, x9
009484b3 // add  x9, x9, x9
009484b3 // add  x9, x9, x9
009484b3 // add  x9, x9, x9
009484b3 // add  x9, x9, x9
008484b3 // add  x9, x9, x8     opB in low byte
0092a023 // sw   x9, 0(x5)      xor operands
0042a503 // lw   x10, 4(x5)     xor result
08a12023 // sw   x10, 0x80(x2)
0102a583 // lw   x11, 16(x5)    product, stalls
0cb12023 // sw   x11, 0xc0(x2)
00410113 // addi x2, x2, 4
00130313 // addi x6, x6, 1
fa1314e3 // bne  x6, x1, loop
14402023 // sw   x4, 0x140(x0)  sum
00000073 // ecall
@20
00001234 00000056 00000062 00061d78
0000ffff 000000ff 00000000 00feff01
00000001 00000001 00000000 00000001
000000a5 0000005a 000000ff 00003a02
00008000 00000002 00000002 00010000
00000f0f 000000f0 000000ff 000e1e10
00007abc 0000003c 00000080 001cc410
00000000 00000077 00000077 00000000

//--- accelTile.f
+incdir+.
accelTile_pkg.sv
accelCoreFarm.sv
miniCore.sv
accelCoreMemWrap.sv
accelCoreTop.sv
tbClockGen.sv
accelTile_assert.sv
accelTile_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
   -f accelTile.f --top-module accelTile_tb -o simv

status=0
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
[ "$status" -eq 0 ] || exit "$status"

if grep -q "STATUS: FAIL" sim.log; then
   exit 1
fi
grep -q "STATUS: PASS" sim.log
